// File: sched_defines.svh
// Array geometry and counter width constants for the matrix-multiply scheduler
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// Systolic array rows and columns
`define SCHED_ARRAY_H 4
`define SCHED_ARRAY_W 4

// Accumulation slots per row, which is also the full Z tile height
`define SCHED_DEPTH 8

// Pipeline registers in each processing element
`define SCHED_PIPE_REGS 2

// Width of one iteration count field, two of them share a 32-bit word
`define SCHED_ITER_W 16

// Width of a tile extent
`define SCHED_SIZE_W 8

// Counter that walks one load period of LOAD_W plus the WAIT cycles
`define SCHED_WAIT_W 2

`endif

// File: tb_matmul_scheduler.sv
// Testbench for the matrix-multiply scheduler driving random jobs against a buffer model
`timescale 1ns/1ps
`include "sched_defines.svh"

module tb_matmul_scheduler;

  localparam int JOBS        = 16;
  localparam int JOB_TIMEOUT = 3000;

  logic                     clk_i, rst_ni, clear_i, start_i, use_y_i;
  logic [31:0]              x_iters_i, w_iters_i, leftovers_i;
  logic                     x_valid_i, w_valid_i, x_empty_i, x_full_i, z_empty_i, z_loaded_i;
  logic                     x_load_o, w_load_o, y_push_o, z_fill_o, reg_enable_o, busy_o;
  logic [`SCHED_SIZE_W-1:0] x_height_o, x_width_o, w_height_o, w_width_o;
  logic [`SCHED_SIZE_W-1:0] z_height_o, z_width_o;

  // Job configuration
  int                       n_xr, n_wr, n_wc;
  logic [7:0]               lo_xh, lo_xw, lo_wh, lo_ww;
  logic                     use_y;

  // Buffer model and reference tile counters
  logic                     x_full, z_loaded, start_due, clear_due, empty_due, zempty_due;
  logic                     z_exp_due, y_seen, timed_out;
  int                       x_delay, y_delay, w_row, w_col, w_mat, z_col, z_row;
  int                       loads, since_load, z_exp, z_exp_w;
  int                       errors, checks, guard, job;

  matmul_scheduler DUT (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic expect_idle(input string name);
    check_value(name, 0, int'({x_load_o, w_load_o, y_push_o, z_fill_o, reg_enable_o, busy_o}));
  endtask

  task automatic reset_model();
    {x_full, z_loaded, start_due, clear_due, empty_due, zempty_due} = '0;
    z_exp_due  = 1'b0;
    y_seen     = 1'b0;
    x_delay    = 0;
    y_delay    = 0;
    w_row      = 0;
    w_col      = 0;
    w_mat      = 0;
    z_col      = 0;
    z_row      = 0;
    loads      = 0;
    since_load = 100;
  endtask

  task automatic drive_inputs();
    clear_i   = clear_due;
    start_i   = start_due;
    clear_due = 1'b0;
    start_due = 1'b0;
    // The X buffer lowers its full flag with the empty pulse
    if (empty_due) x_full = 1'b0;
    x_empty_i  = empty_due;
    z_empty_i  = zempty_due;
    empty_due  = 1'b0;
    zempty_due = 1'b0;
    if (x_delay > 0) begin
      x_delay--;
      if (x_delay == 0) x_full = 1'b1;
    end
    if (y_delay > 0) begin
      y_delay--;
      if (y_delay == 0) z_loaded = 1'b1;
    end
    x_full_i    = x_full;
    z_loaded_i  = z_loaded;
    w_valid_i   = ($urandom % 4) != 0;
    use_y_i     = use_y;
    x_iters_i   = {16'(n_xr), 16'(n_wr)};
    w_iters_i   = {16'(n_wr), 16'(n_wc)};
    leftovers_i = {lo_xh, lo_xw, lo_wh, lo_ww};
  endtask

  task automatic sample_outputs();
    int exp_w, exp_h, exp_xw, exp_xh;
    if (z_loaded_i) y_seen = 1'b1;
    if (z_exp_due) begin
      check_value("z_height after Z empty", z_exp, int'(z_height_o));
      check_value("z_width after Z empty", z_exp_w, int'(z_width_o));
      z_exp_due = 1'b0;
    end
    // Each Z empty pulse latches the size of the current Y tile
    if (z_empty_i) begin
      z_exp   = (z_col == n_wc - 1 && lo_ww != 0) ? int'(lo_ww) : `SCHED_DEPTH;
      z_exp_w = (z_row == n_wr - 1 && lo_wh != 0) ? int'(lo_wh) : `SCHED_ARRAY_W;
      if (z_col == n_wc - 1) begin
        z_col = 0;
        z_row = (z_row == n_wr - 1) ? 0 : z_row + 1;
      end else begin
        z_col++;
      end
      z_exp_due = 1'b1;
    end
    if (x_load_o && x_delay == 0) x_delay = 1 + $urandom % 4;
    if (w_load_o) begin
      exp_w  = (w_col == n_wc - 1 && lo_ww != 0) ? int'(lo_ww) : `SCHED_DEPTH;
      exp_h  = (w_row == n_wr - 1 && lo_wh != 0) ? int'(lo_wh) : `SCHED_ARRAY_H;
      // The X tile in use follows the W row and the W matrix pass
      exp_xw = (w_row == n_wr - 1 && lo_xw != 0) ? int'(lo_xw) : `SCHED_DEPTH;
      exp_xh = (w_mat == n_xr - 1 && lo_xh != 0) ? int'(lo_xh) : `SCHED_ARRAY_W;
      check_value("w_valid during w_load", 1, int'(w_valid_i));
      check_value("w_load spacing", 1, int'(since_load >= `SCHED_PIPE_REGS));
      if (use_y) check_value("z_loaded before w_load", 1, int'(y_seen));
      check_value("w_width", exp_w, int'(w_width_o));
      check_value("w_height", exp_h, int'(w_height_o));
      check_value("x_width", exp_xw, int'(x_width_o));
      check_value("x_height", exp_xh, int'(x_height_o));
      loads++;
      since_load = 0;
      // One X tile is used up per W row
      empty_due = 1'b1;
      if (w_row == n_wr - 1) begin
        w_row      = 0;
        zempty_due = 1'b1;
        if (w_col == n_wc - 1) begin
          w_col = 0;
          w_mat++;
        end else begin
          w_col++;
        end
      end else begin
        w_row++;
      end
    end else begin
      since_load++;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    drive_inputs();
    #5;
    sample_outputs();
  endtask

  initial begin
    void'($urandom(32'hcef));
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    {clear_i, start_i, use_y_i, x_empty_i, x_full_i, z_empty_i, z_loaded_i} = '0;
    x_valid_i   = 1'b1;
    w_valid_i   = 1'b0;
    x_iters_i   = '0;
    w_iters_i   = '0;
    leftovers_i = '0;
    {n_xr, n_wr, n_wc} = {32'd1, 32'd1, 32'd1};
    {lo_xh, lo_xw, lo_wh, lo_ww} = '0;
    use_y = 1'b0;
    reset_model();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #5;
    expect_idle("outputs after reset");
    for (job = 0; job < JOBS && !timed_out; job++) begin
      n_xr  = 1 + $urandom % 3;
      n_wr  = 1 + $urandom % 3;
      n_wc  = 1 + $urandom % 3;
      lo_xh = 8'($urandom % 4);
      lo_xw = 8'($urandom % 8);
      lo_wh = 8'($urandom % 4);
      lo_ww = ($urandom % 3 == 0) ? 8'd0 : 8'(1 + $urandom % 7);
      use_y = ($urandom % 2) == 1;
      reset_model();
      clear_due = 1'b1;
      run_cycle();
      run_cycle();
      // Part of a job runs and is then cut short by clear_i
      start_due = 1'b1;
      y_delay   = use_y ? 1 + $urandom % 12 : 0;
      run_cycle();
      repeat (2 + $urandom % 30) run_cycle();
      clear_due = 1'b1;
      run_cycle();
      reset_model();
      run_cycle();
      expect_idle("outputs after clear");
      start_due = 1'b1;
      y_delay   = use_y ? 1 + $urandom % 12 : 0;
      run_cycle();
      guard = 0;
      do begin
        run_cycle();
        guard++;
      end while (busy_o && guard < JOB_TIMEOUT);
      if (busy_o) begin
        $display("Job %0d did not finish, busy_o still high after %0d cycles", job, guard);
        errors++;
        timed_out = 1'b1;
      end else begin
        check_value("w_load count", n_xr * n_wr * n_wc, loads);
      end
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: sched_state_pkg.sv
// Sequencer state encoding shared by the scheduler FSM and its testbench
package sched_state_pkg;

  // PRELOAD fills the X buffer (and Y when used) before any W row goes in
  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_state_e;

endpackage

// File: sched_tile_pkg.sv
// Tile extent helpers shared by the X, W and Z tile logic
`include "sched_defines.svh"

package sched_tile_pkg;

  // True when idx is the final tile of a run of count tiles
  function automatic logic is_last(
    input logic [`SCHED_ITER_W-1:0] idx,
    input logic [`SCHED_ITER_W-1:0] count
  );
    return idx == count - 1'b1;
  endfunction

  // Final tile shrinks to the leftover size, a zero leftover means the tile is full
  function automatic logic [`SCHED_SIZE_W-1:0] tile_extent(
    input logic [`SCHED_ITER_W-1:0] idx,
    input logic [`SCHED_ITER_W-1:0] count,
    input logic [`SCHED_SIZE_W-1:0] leftover,
    input logic [`SCHED_SIZE_W-1:0] full
  );
    if (is_last(idx, count) && leftover != '0) begin
      return leftover;
    end
    return full;
  endfunction

endpackage

// File: x_tile_iter.sv
// X operand tile iterator with reload request, refill tracking and done detection
`timescale 1ns/1ps
`include "sched_defines.svh"

module x_tile_iter
  import sched_tile_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  logic                      x_valid_i,
  input  logic                      x_empty_i,
  input  logic                      x_full_i,
  input  logic [31:0]               x_iters_i,
  input  logic [31:0]               w_iters_i,
  input  logic [31:0]               leftovers_i,
  output logic                      x_load_o,
  output logic [`SCHED_SIZE_W-1:0]  x_height_o,
  output logic [`SCHED_SIZE_W-1:0]  x_width_o,
  output logic                      x_done_o,
  output logic                      x_refill_o
);

  logic [`SCHED_ITER_W-1:0] cols_q, wpass_q, rows_q;
  logic                     cols_last, wpass_last, rows_last;
  logic                     cols_en, wpass_en, rows_en, done_en;
  logic                     done_q, reload_q, refill_q;

  assign cols_last  = is_last(cols_q, x_iters_i[15:0]);
  assign wpass_last = is_last(wpass_q, w_iters_i[15:0]);
  assign rows_last  = is_last(rows_q, x_iters_i[31:16]);

  // The empty flag is a one-cycle pulse per consumed tile
  assign cols_en  = x_empty_i && ~done_q;
  assign wpass_en = cols_en && cols_last;
  assign rows_en  = wpass_en && wpass_last;
  assign done_en  = x_load_o && cols_last && wpass_last && rows_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q  <= '0;
      wpass_q <= '0;
      rows_q  <= '0;
    end else if (clear_i || start_i) begin
      cols_q  <= '0;
      wpass_q <= '0;
      rows_q  <= '0;
    end else begin
      if (cols_en) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
      end
      if (wpass_en) begin
        wpass_q <= wpass_last ? '0 : wpass_q + 1'b1;
      end
      if (rows_en) begin
        rows_q <= rows_last ? '0 : rows_q + 1'b1;
      end
    end
  end

  // The buffer drops x_full_i together with its x_empty_i pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q   <= 1'b0;
      reload_q <= 1'b0;
      refill_q <= 1'b0;
    end else if (clear_i) begin
      done_q   <= 1'b0;
      reload_q <= 1'b0;
      refill_q <= 1'b0;
    end else if (start_i) begin
      done_q   <= 1'b0;
      reload_q <= 1'b1;
      refill_q <= 1'b0;
    end else begin
      if (done_en) begin
        done_q <= 1'b1;
      end
      if (cols_en) begin
        reload_q <= 1'b1;
        refill_q <= 1'b1;
      end else if (x_full_i) begin
        reload_q <= 1'b0;
        refill_q <= 1'b0;
      end
    end
  end

  assign x_load_o   = reload_q && ~x_full_i && x_valid_i;
  assign x_done_o   = done_q;
  assign x_refill_o = refill_q;

  assign x_height_o = tile_extent(rows_q, x_iters_i[31:16], leftovers_i[31:24],
                                  `SCHED_SIZE_W'(`SCHED_ARRAY_W));
  assign x_width_o  = tile_extent(cols_q, x_iters_i[15:0], leftovers_i[23:16],
                                  `SCHED_SIZE_W'(`SCHED_DEPTH));

endmodule

// File: w_tile_iter.sv
// W operand tile iterator issuing one W row per unstalled LOAD_W cycle
`timescale 1ns/1ps
`include "sched_defines.svh"

module w_tile_iter
  import sched_state_pkg::*;
  import sched_tile_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  sched_state_e              state_i,
  input  logic                      stall_i,
  input  logic                      w_valid_i,
  input  logic [31:0]               x_iters_i,
  input  logic [31:0]               w_iters_i,
  input  logic [31:0]               leftovers_i,
  output logic                      w_load_o,
  output logic [`SCHED_SIZE_W-1:0]  w_height_o,
  output logic [`SCHED_SIZE_W-1:0]  w_width_o,
  output logic                      w_done_o,
  output logic                      w_col_step_o
);

  logic [`SCHED_ITER_W-1:0] rows_q, cols_q, mat_q;
  logic                     rows_last, cols_last;
  logic                     mat_en, done_en;
  logic                     done_q;

  assign rows_last = is_last(rows_q, w_iters_i[31:16]);
  assign cols_last = is_last(cols_q, w_iters_i[15:0]);

  assign w_load_o     = (state_i == LOAD_W) && ~stall_i && ~done_q && w_valid_i;
  assign w_col_step_o = w_load_o && rows_last;
  assign mat_en       = w_col_step_o && cols_last;

  // The whole W matrix is streamed once per X row tile
  assign done_en = mat_en && is_last(mat_q, x_iters_i[31:16]);

  // Counters restart whenever the sequencer is idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
      cols_q <= '0;
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (clear_i || state_i == IDLE) begin
      rows_q <= '0;
      cols_q <= '0;
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (w_load_o) begin
      rows_q <= rows_last ? '0 : rows_q + 1'b1;
      if (w_col_step_o) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
      end
      if (mat_en) begin
        mat_q <= mat_q + 1'b1;
      end
      if (done_en) begin
        done_q <= 1'b1;
      end
    end
  end

  assign w_done_o = done_q;

  assign w_height_o = tile_extent(rows_q, w_iters_i[31:16], leftovers_i[15:8],
                                  `SCHED_SIZE_W'(`SCHED_ARRAY_H));
  assign w_width_o  = tile_extent(cols_q, w_iters_i[15:0], leftovers_i[7:0],
                                  `SCHED_SIZE_W'(`SCHED_DEPTH));

endmodule

// File: z_drain_ctrl.sv
// Y push and Z drain control, timed from the end of each W column pass
`timescale 1ns/1ps
`include "sched_defines.svh"

module z_drain_ctrl
  import sched_tile_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      stall_i,
  input  logic                      start_comp_i,
  input  logic                      w_col_step_i,
  input  logic                      reg_enable_i,
  input  logic                      z_empty_i,
  input  logic [31:0]               w_iters_i,
  input  logic [31:0]               leftovers_i,
  output logic                      y_push_o,
  output logic                      z_fill_o,
  output logic [`SCHED_SIZE_W-1:0]  z_height_o,
  output logic [`SCHED_SIZE_W-1:0]  z_width_o,
  output logic                      z_check_o,
  output logic                      z_avail_clr_o
);

  logic [`SCHED_ITER_W-1:0] y_cols_q, y_rows_q;
  logic [`SCHED_WAIT_W-1:0] wait_q;
  logic [`SCHED_SIZE_W-1:0] avail_q, push_q, y_height, y_width;
  logic                     wait_en, avail_en, push_en;
  logic                     y_cols_last, wait_clr, avail_clr, push_set, push_clr;

  assign y_cols_last = is_last(y_cols_q, w_iters_i[15:0]);
  assign y_height = tile_extent(y_cols_q, w_iters_i[15:0], leftovers_i[7:0],
                                `SCHED_SIZE_W'(`SCHED_DEPTH));
  assign y_width  = tile_extent(y_rows_q, w_iters_i[31:16], leftovers_i[15:8],
                                `SCHED_SIZE_W'(`SCHED_ARRAY_W));

  assign z_check_o = wait_q == `SCHED_WAIT_W'(`SCHED_PIPE_REGS);
  assign wait_clr  = wait_en && ~stall_i && z_check_o;
  assign avail_clr = avail_en && ~stall_i && avail_q == z_height_o - 1'b1;
  assign push_clr  = push_en && ~stall_i && push_q == y_height - 1'b1;
  // Y rows enter one cycle ahead of the first Z row leaving the array
  assign push_set  = wait_en && ~stall_i && wait_q == `SCHED_WAIT_W'(`SCHED_PIPE_REGS - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {wait_en, avail_en, push_en} <= '0;
      wait_q   <= '0;
      avail_q  <= '0;
      push_q   <= '0;
      y_cols_q <= '0;
      y_rows_q <= '0;
    end else if (clear_i) begin
      {wait_en, avail_en, push_en} <= '0;
      wait_q   <= '0;
      avail_q  <= '0;
      push_q   <= '0;
      y_cols_q <= '0;
      y_rows_q <= '0;
    end else begin
      if (w_col_step_i) wait_en <= 1'b1;
      else if (wait_clr) wait_en <= 1'b0;
      if (wait_en && ~stall_i) wait_q <= z_check_o ? '0 : wait_q + 1'b1;
      // A new pass restarts the count so the last pass always drains last
      if (wait_clr) avail_en <= 1'b1;
      else if (avail_clr) avail_en <= 1'b0;
      if (wait_clr) avail_q <= '0;
      else if (avail_en && ~stall_i) avail_q <= avail_clr ? '0 : avail_q + 1'b1;
      if (push_set || start_comp_i) push_en <= 1'b1;
      else if (push_clr) push_en <= 1'b0;
      if (push_en && ~stall_i) push_q <= push_clr ? '0 : push_q + 1'b1;
      if (z_empty_i) begin
        y_cols_q <= y_cols_last ? '0 : y_cols_q + 1'b1;
        if (y_cols_last) y_rows_q <= is_last(y_rows_q, w_iters_i[31:16]) ? '0 : y_rows_q + 1'b1;
      end
    end
  end

  // Z tile size is taken when the buffer frees up or the first pass starts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      z_height_o <= '0;
      z_width_o  <= '0;
    end else if (clear_i) begin
      z_height_o <= '0;
      z_width_o  <= '0;
    end else if (z_empty_i || start_comp_i) begin
      z_height_o <= y_height;
      z_width_o  <= y_width;
    end
  end

  assign y_push_o      = push_en && ~stall_i;
  assign z_fill_o      = avail_en && reg_enable_i;
  // Only a drain with no wait in flight counts as the end of the Z tile stream
  assign z_avail_clr_o = avail_clr && ~wait_en;

endmodule

// File: sched_sequencer.sv
// Scheduler FSM with the stall checks and the array register enable
`timescale 1ns/1ps
`include "sched_defines.svh"

module sched_sequencer
  import sched_state_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          start_i,
  input  logic          use_y_i,
  input  logic          x_full_i,
  input  logic          z_loaded_i,
  input  logic          w_valid_i,
  input  logic          x_done_i,
  input  logic          x_refill_i,
  input  logic          w_done_i,
  input  logic          z_check_i,
  input  logic          z_avail_clr_i,
  output sched_state_e  state_o,
  output logic          stall_o,
  output logic          computing_o,
  output logic          start_comp_o,
  output logic          reg_enable_o
);

  sched_state_e             state_q, state_d;
  logic [`SCHED_WAIT_W-1:0] wait_cnt_q;
  logic                     wait_end, job_end, preload_ok;
  logic                     w_missing, y_missing, x_missing;
  logic                     first_load_q, computing_q, drained_q;

  assign wait_end = wait_cnt_q == `SCHED_WAIT_W'(`SCHED_PIPE_REGS);

  // W and Y are checked while loading, the X refill one cycle early in WAIT
  assign w_missing = ~w_valid_i && ~w_done_i;
  assign y_missing = use_y_i && z_check_i && ~z_loaded_i && ~w_done_i;
  assign x_missing = x_refill_i && ~x_full_i && ~x_done_i;
  assign stall_o   = (state_q == LOAD_W && (w_missing || y_missing)) ||
                     (state_q == WAIT && x_missing);

  assign preload_ok = x_full_i && (z_loaded_i || ~use_y_i);
  assign job_end    = state_q == LOAD_W && w_done_i && (z_avail_clr_i || drained_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = PRELOAD;
      PRELOAD: if (preload_ok) state_d = LOAD_W;
      LOAD_W: begin
        if (job_end) begin
          state_d = IDLE;
        end else if (~stall_o) begin
          state_d = WAIT;
        end
      end
      WAIT:    if (wait_end && ~stall_o) state_d = LOAD_W;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      wait_cnt_q   <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      drained_q    <= 1'b0;
      reg_enable_o <= 1'b0;
    end else if (clear_i) begin
      state_q      <= IDLE;
      wait_cnt_q   <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      drained_q    <= 1'b0;
      reg_enable_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      reg_enable_o <= computing_q && ~stall_o;
      if (state_q == IDLE) begin
        wait_cnt_q   <= '0;
        first_load_q <= 1'b1;
        drained_q    <= 1'b0;
      end else if (state_q != PRELOAD && ~stall_o) begin
        wait_cnt_q <= wait_end ? '0 : wait_cnt_q + 1'b1;
      end
      if (state_q == LOAD_W && ~stall_o) first_load_q <= 1'b0;
      // The last Z drain may finish in WAIT, so it is held until the next LOAD_W
      if (w_done_i && z_avail_clr_i) drained_q <= 1'b1;
      if (state_q == PRELOAD && state_d == LOAD_W) computing_q <= 1'b1;
      else if (job_end) computing_q <= 1'b0;
    end
  end

  assign state_o      = state_q;
  assign computing_o  = computing_q;
  assign start_comp_o = first_load_q && state_d == LOAD_W && ~stall_o;

endmodule

// File: matmul_scheduler.sv
// Matrix-multiply scheduler top joining the tile iterators, Z drain and FSM
`timescale 1ns/1ps
`include "sched_defines.svh"

module matmul_scheduler
  import sched_state_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  logic                      use_y_i,
  input  logic [31:0]               x_iters_i,
  input  logic [31:0]               w_iters_i,
  input  logic [31:0]               leftovers_i,
  input  logic                      x_valid_i,
  input  logic                      w_valid_i,
  input  logic                      x_empty_i,
  input  logic                      x_full_i,
  input  logic                      z_empty_i,
  input  logic                      z_loaded_i,
  output logic                      x_load_o,
  output logic [`SCHED_SIZE_W-1:0]  x_height_o,
  output logic [`SCHED_SIZE_W-1:0]  x_width_o,
  output logic                      w_load_o,
  output logic [`SCHED_SIZE_W-1:0]  w_height_o,
  output logic [`SCHED_SIZE_W-1:0]  w_width_o,
  output logic                      y_push_o,
  output logic                      z_fill_o,
  output logic [`SCHED_SIZE_W-1:0]  z_height_o,
  output logic [`SCHED_SIZE_W-1:0]  z_width_o,
  output logic                      reg_enable_o,
  output logic                      busy_o
);

  sched_state_e state;
  logic         stall, computing, start_comp;
  logic         x_done, x_refill, w_done, w_col_step, z_check, z_avail_clr;

  // Busy spans the preload and every cycle of the computation
  assign busy_o = computing || state == PRELOAD;

  sched_sequencer u_sequencer (
    .clk_i, .rst_ni, .clear_i, .start_i, .use_y_i, .x_full_i, .z_loaded_i, .w_valid_i,
    .x_done_i(x_done), .x_refill_i(x_refill), .w_done_i(w_done), .z_check_i(z_check),
    .z_avail_clr_i(z_avail_clr), .state_o(state), .stall_o(stall),
    .computing_o(computing), .start_comp_o(start_comp), .reg_enable_o
  );

  x_tile_iter u_x_iter (
    .clk_i, .rst_ni, .clear_i, .start_i, .x_valid_i, .x_empty_i, .x_full_i,
    .x_iters_i, .w_iters_i, .leftovers_i, .x_load_o, .x_height_o, .x_width_o,
    .x_done_o(x_done), .x_refill_o(x_refill)
  );

  w_tile_iter u_w_iter (
    .clk_i, .rst_ni, .clear_i, .state_i(state), .stall_i(stall), .w_valid_i,
    .x_iters_i, .w_iters_i, .leftovers_i, .w_load_o, .w_height_o, .w_width_o,
    .w_done_o(w_done), .w_col_step_o(w_col_step)
  );

  z_drain_ctrl u_z_drain (
    .clk_i, .rst_ni, .clear_i, .stall_i(stall), .start_comp_i(start_comp),
    .w_col_step_i(w_col_step), .reg_enable_i(reg_enable_o), .z_empty_i, .w_iters_i,
    .leftovers_i, .y_push_o, .z_fill_o, .z_height_o, .z_width_o,
    .z_check_o(z_check), .z_avail_clr_o(z_avail_clr)
  );

endmodule

// File: project.f
+incdir+.
tb_matmul_scheduler.sv
sched_state_pkg.sv
sched_tile_pkg.sv
x_tile_iter.sv
w_tile_iter.sv
z_drain_ctrl.sv
sched_sequencer.sv
matmul_scheduler.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scheduler testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1
verilator --binary -f project.f --top-module tb_matmul_scheduler \
  -Mdir obj_dir -o tb_matmul_scheduler > build.log 2>&1 \
  && ./obj_dir/tb_matmul_scheduler > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
